/* rtl/kd_ctrl_pkg.sv */
package kd_ctrl_pkg;

    localparam int DATA_WIDTH = 11;
    localparam int PATCH_SIZE = 5;
    localparam int LEAF_SIZE = 8;
    localparam int NUM_LEAVES = 8;
    localparam int NUM_NODES = NUM_LEAVES - 1;
    localparam int NUM_QUERIES = 6;
    localparam int LOAD_CREDITS = 2;
    localparam int OUT_CREDITS = 4;
    // kernel, running min and sorter latency
    localparam int SCAN_FLUSH_CYCLES = 12;

    localparam int LEAF_AW = $clog2(NUM_LEAVES);
    localparam int NODE_AW = $clog2(NUM_NODES);
    localparam int QUERY_AW = $clog2(NUM_QUERIES);
    localparam int BANK_W = $clog2(LEAF_SIZE);
    // the leaf load is the longest phase
    localparam int STEP_W = $clog2(NUM_LEAVES * LEAF_SIZE);
    localparam int RD_AW = (LEAF_AW > QUERY_AW) ? LEAF_AW : QUERY_AW;
    localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

    typedef enum logic [2:0] {
        idle,
        load_nodes,
        load_leaves,
        load_queries,
        scan_leaves,
        scan_flush,
        send_best
    } phase_t;

    typedef logic signed [PATCH_SIZE-1:0][DATA_WIDTH-1:0] patch_t;

    typedef struct packed {
        logic               node_en;
        logic [NODE_AW-1:0] node_addr;
        logic [LEAF_SIZE-1:0] leaf_bank_sel;
        logic [LEAF_AW-1:0] leaf_addr;
        logic               query_en;
        logic [QUERY_AW-1:0] query_addr;
    } load_wr_t;

    typedef struct packed {
        logic             en;
        logic [RD_AW-1:0] addr;
    } mem_rd_t;

    typedef struct packed {
        logic   valid;
        logic   first;
        logic   last;
        patch_t patch;
    } kernel_beat_t;

    typedef struct packed {
        logic                en;
        logic [QUERY_AW-1:0] addr;
    } best_wr_t;

    typedef struct packed {
        logic               enq;
        logic [LEAF_AW-1:0] leaf_idx;
    } out_word_t;

endpackage

/* rtl/phase_fsm.sv */
`timescale 1ns/100ps

module phase_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_kdtree,
    input  logic                start,
    input  logic                send_best_cmd,
    input  logic                agg_valid,
    input  logic                out_enq,
    input  logic                last,
    output kd_ctrl_pkg::phase_t phase,
    output logic                step,
    output logic                done
);

    kd_ctrl_pkg::phase_t phase_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= kd_ctrl_pkg::idle;
        end else begin
            phase <= phase_next;
        end
    end

    // what advances the step counter in each phase
    always_comb begin
        case (phase)
            kd_ctrl_pkg::load_nodes,
            kd_ctrl_pkg::load_leaves,
            kd_ctrl_pkg::load_queries: step = agg_valid;
            kd_ctrl_pkg::scan_leaves,
            kd_ctrl_pkg::scan_flush:   step = 1'b1;
            kd_ctrl_pkg::send_best:    step = out_enq;
            default:                   step = 1'b0;
        endcase
    end

    always_comb begin
        phase_next = phase;
        case (phase)
            kd_ctrl_pkg::idle: begin
                // commands only count here
                if (load_kdtree) begin
                    phase_next = kd_ctrl_pkg::load_nodes;
                end else if (start) begin
                    phase_next = kd_ctrl_pkg::scan_leaves;
                end else if (send_best_cmd) begin
                    phase_next = kd_ctrl_pkg::send_best;
                end
            end
            kd_ctrl_pkg::load_nodes: begin
                if (step && last) begin
                    phase_next = kd_ctrl_pkg::load_leaves;
                end
            end
            kd_ctrl_pkg::load_leaves: begin
                if (step && last) begin
                    phase_next = kd_ctrl_pkg::load_queries;
                end
            end
            kd_ctrl_pkg::scan_leaves: begin
                if (last) begin
                    phase_next = kd_ctrl_pkg::scan_flush;
                end
            end
            kd_ctrl_pkg::load_queries,
            kd_ctrl_pkg::scan_flush,
            kd_ctrl_pkg::send_best: begin
                if (step && last) begin
                    phase_next = kd_ctrl_pkg::idle;
                end
            end
            default: phase_next = kd_ctrl_pkg::idle;
        endcase
    end

    // pipeline drained, all kernel results are in the best array
    assign done = (phase == kd_ctrl_pkg::scan_flush) && last;

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({load_kdtree, start, send_best_cmd}));

endmodule

/* rtl/phase_counter.sv */
`timescale 1ns/100ps

module phase_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  kd_ctrl_pkg::phase_t            phase,
    input  logic                           step,
    output logic [kd_ctrl_pkg::STEP_W-1:0] count,
    output logic                           last
);

    kd_ctrl_pkg::phase_t              phase_q;
    logic [kd_ctrl_pkg::STEP_W-1:0]   count_q;
    logic [kd_ctrl_pkg::STEP_W-1:0]   terminal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= kd_ctrl_pkg::idle;
            count_q <= '0;
        end else begin
            phase_q <= phase;
            if (step) begin
                count_q <= last ? '0 : count + 1'b1;
            end else begin
                count_q <= count;
            end
        end
    end

    // every phase starts counting from zero
    assign count = (phase != phase_q) ? '0 : count_q;

    always_comb begin
        case (phase)
            kd_ctrl_pkg::load_nodes:
                terminal = kd_ctrl_pkg::STEP_W'(kd_ctrl_pkg::NUM_NODES - 1);
            kd_ctrl_pkg::load_leaves:
                terminal = kd_ctrl_pkg::STEP_W'(kd_ctrl_pkg::NUM_LEAVES * kd_ctrl_pkg::LEAF_SIZE - 1);
            kd_ctrl_pkg::scan_leaves:
                terminal = kd_ctrl_pkg::STEP_W'(kd_ctrl_pkg::NUM_LEAVES * kd_ctrl_pkg::NUM_QUERIES - 1);
            kd_ctrl_pkg::scan_flush:
                terminal = kd_ctrl_pkg::STEP_W'(kd_ctrl_pkg::SCAN_FLUSH_CYCLES - 1);
            kd_ctrl_pkg::load_queries,
            kd_ctrl_pkg::send_best:
                terminal = kd_ctrl_pkg::STEP_W'(kd_ctrl_pkg::NUM_QUERIES - 1);
            default:
                terminal = '0;
        endcase
    end

    assign last = (count == terminal);

endmodule

/* rtl/load_writer.sv */
`timescale 1ns/100ps

module load_writer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  kd_ctrl_pkg::phase_t            phase,
    input  logic                           agg_valid,
    input  logic [kd_ctrl_pkg::STEP_W-1:0] count,
    output kd_ctrl_pkg::load_wr_t          load_wr,
    output logic                           agg_credit
);

    logic [kd_ctrl_pkg::LEAF_SIZE-1:0] bank_onehot;

    // leaf words are spread over the banks by the low count bits
    always_comb begin
        bank_onehot = '0;
        bank_onehot[count[kd_ctrl_pkg::BANK_W-1:0]] = 1'b1;
    end

    always_comb begin
        load_wr.node_en = agg_valid && (phase == kd_ctrl_pkg::load_nodes);
        load_wr.node_addr = count[kd_ctrl_pkg::NODE_AW-1:0];
        load_wr.leaf_bank_sel = (agg_valid && (phase == kd_ctrl_pkg::load_leaves)) ?
                                bank_onehot : '0;
        load_wr.leaf_addr = count[kd_ctrl_pkg::BANK_W +: kd_ctrl_pkg::LEAF_AW];
        load_wr.query_en = agg_valid && (phase == kd_ctrl_pkg::load_queries);
        load_wr.query_addr = count[kd_ctrl_pkg::QUERY_AW-1:0];
    end

    // each word is consumed at once, its credit goes back next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            agg_credit <= 1'b0;
        end else begin
            agg_credit <= agg_valid;
        end
    end

    a_word_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        agg_valid |-> phase inside {kd_ctrl_pkg::load_nodes, kd_ctrl_pkg::load_leaves,
                                    kd_ctrl_pkg::load_queries});

endmodule

/* rtl/scan_sequencer.sv */
`timescale 1ns/100ps

module scan_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  kd_ctrl_pkg::phase_t            phase,
    input  logic                           start,
    input  logic [kd_ctrl_pkg::STEP_W-1:0] count,
    input  kd_ctrl_pkg::patch_t            query_rdata,
    output kd_ctrl_pkg::mem_rd_t           leaf_rd,
    output kd_ctrl_pkg::mem_rd_t           query_rd,
    output kd_ctrl_pkg::kernel_beat_t      kernel
);

    logic [kd_ctrl_pkg::LEAF_AW-1:0]  leaf_idx;
    logic [kd_ctrl_pkg::QUERY_AW-1:0] query_idx;
    logic                             scanning;
    logic                             first_beat;
    logic                             last_beat;
    kd_ctrl_pkg::patch_t              held_patch;

    assign leaf_idx = count[kd_ctrl_pkg::LEAF_AW-1:0];
    assign query_idx = count[kd_ctrl_pkg::LEAF_AW +: kd_ctrl_pkg::QUERY_AW];
    assign scanning = (phase == kd_ctrl_pkg::scan_leaves);
    assign first_beat = scanning && (leaf_idx == '0);
    assign last_beat = scanning &&
                       (leaf_idx == kd_ctrl_pkg::LEAF_AW'(kd_ctrl_pkg::NUM_LEAVES - 1));

    // query 0 is read on start, the next one during the last beat of the current one
    always_comb begin
        if ((phase == kd_ctrl_pkg::idle) && start) begin
            query_rd.en = 1'b1;
            query_rd.addr = '0;
        end else begin
            query_rd.en = last_beat &&
                (query_idx != kd_ctrl_pkg::QUERY_AW'(kd_ctrl_pkg::NUM_QUERIES - 1));
            query_rd.addr = kd_ctrl_pkg::RD_AW'(query_idx + 1'b1);
        end
    end

    // read data is live on the first beat only
    always_ff @(posedge clk) begin
        if (first_beat) begin
            held_patch <= query_rdata;
        end
    end

    always_comb begin
        leaf_rd.en = scanning;
        leaf_rd.addr = kd_ctrl_pkg::RD_AW'(leaf_idx);
        kernel.valid = scanning;
        kernel.first = first_beat;
        kernel.last = last_beat;
        if (!scanning) begin
            kernel.patch = '0;
        end else if (first_beat) begin
            kernel.patch = query_rdata;
        end else begin
            kernel.patch = held_patch;
        end
    end

    // the read for the next query lands right on its first beat
    a_read_then_first: assert property (@(posedge clk) disable iff (!rst_n)
        query_rd.en |=> kernel.first);

endmodule

/* rtl/result_reader.sv */
`timescale 1ns/100ps

module result_reader (
    input  logic                            clk,
    input  logic                            rst_n,
    input  kd_ctrl_pkg::phase_t             phase,
    input  logic                            done,
    input  logic                            kernel_result,
    input  logic [kd_ctrl_pkg::LEAF_AW-1:0] best_rdata,
    input  logic                            out_credit,
    output kd_ctrl_pkg::best_wr_t           best_wr,
    output kd_ctrl_pkg::mem_rd_t            best_rd,
    output kd_ctrl_pkg::out_word_t          out
);

    logic [kd_ctrl_pkg::QUERY_AW-1:0] best_addr_q;
    logic [kd_ctrl_pkg::QUERY_AW-1:0] rd_addr_q;
    logic [kd_ctrl_pkg::CREDIT_W-1:0] credit_q;
    logic                             enq_q;
    logic                             rd_go;

    // one result per query, in query order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_addr_q <= '0;
        end else if (done) begin
            best_addr_q <= '0;
        end else if (kernel_result) begin
            best_addr_q <= best_addr_q + 1'b1;
        end
    end

    // one read in flight at most, and never without a free FIFO slot
    assign rd_go = (phase == kd_ctrl_pkg::send_best) && (credit_q != '0) && !enq_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_q <= '0;
            enq_q <= 1'b0;
            credit_q <= kd_ctrl_pkg::CREDIT_W'(kd_ctrl_pkg::OUT_CREDITS);
        end else begin
            enq_q <= rd_go;
            if (rd_go) begin
                rd_addr_q <= (rd_addr_q == kd_ctrl_pkg::QUERY_AW'(kd_ctrl_pkg::NUM_QUERIES - 1)) ?
                             '0 : rd_addr_q + 1'b1;
            end
            case ({out_credit, enq_q})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_comb begin
        best_wr.en = kernel_result;
        best_wr.addr = best_addr_q;
        best_rd.en = rd_go;
        best_rd.addr = kd_ctrl_pkg::RD_AW'(rd_addr_q);
        out.enq = enq_q;
        out.leaf_idx = best_rdata;
    end

    // the FIFO returns no more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_credit && !enq_q |-> credit_q < kd_ctrl_pkg::CREDIT_W'(kd_ctrl_pkg::OUT_CREDITS));

endmodule

/* rtl/kd_ctrl_top.sv */
`timescale 1ns/100ps

module kd_ctrl_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_kdtree,
    input  logic                            start,
    input  logic                            send_best_cmd,
    input  logic                            agg_valid,
    input  kd_ctrl_pkg::patch_t             query_rdata,
    input  logic                            kernel_result,
    input  logic [kd_ctrl_pkg::LEAF_AW-1:0] best_rdata,
    input  logic                            out_credit,
    output logic                            agg_credit,
    output kd_ctrl_pkg::load_wr_t           load_wr,
    output kd_ctrl_pkg::mem_rd_t            leaf_rd,
    output kd_ctrl_pkg::mem_rd_t            query_rd,
    output kd_ctrl_pkg::kernel_beat_t       kernel,
    output kd_ctrl_pkg::best_wr_t           best_wr,
    output kd_ctrl_pkg::mem_rd_t            best_rd,
    output kd_ctrl_pkg::out_word_t          out,
    output logic                            done
);

    kd_ctrl_pkg::phase_t            phase;
    logic                           step;
    logic                           last;
    logic [kd_ctrl_pkg::STEP_W-1:0] count;

    phase_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_kdtree   (load_kdtree),
        .start         (start),
        .send_best_cmd (send_best_cmd),
        .agg_valid     (agg_valid),
        .out_enq       (out.enq),
        .last          (last),
        .phase         (phase),
        .step          (step),
        .done          (done)
    );

    phase_counter u_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .phase (phase),
        .step  (step),
        .count (count),
        .last  (last)
    );

    load_writer u_load (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .agg_valid  (agg_valid),
        .count      (count),
        .load_wr    (load_wr),
        .agg_credit (agg_credit)
    );

    scan_sequencer u_scan (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase       (phase),
        .start       (start),
        .count       (count),
        .query_rdata (query_rdata),
        .leaf_rd     (leaf_rd),
        .query_rd    (query_rd),
        .kernel      (kernel)
    );

    result_reader u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase         (phase),
        .done          (done),
        .kernel_result (kernel_result),
        .best_rdata    (best_rdata),
        .out_credit    (out_credit),
        .best_wr       (best_wr),
        .best_rd       (best_rd),
        .out           (out)
    );

endmodule

/* tests/kd_ctrl_tb.sv */
`timescale 1ns/100ps

module kd_ctrl_tb;

    localparam int CLK_PERIOD = 40;
    localparam int LEAF_WORDS = kd_ctrl_pkg::NUM_LEAVES * kd_ctrl_pkg::LEAF_SIZE;
    localparam int LOAD_WORDS = kd_ctrl_pkg::NUM_NODES + LEAF_WORDS + kd_ctrl_pkg::NUM_QUERIES;
    localparam int SCAN_BEATS = kd_ctrl_pkg::NUM_LEAVES * kd_ctrl_pkg::NUM_QUERIES;
    // about two cycles per word and four per readout, plus reset and idle gaps
    localparam int WATCHDOG_CYCLES = 4 * (2 * LOAD_WORDS + SCAN_BEATS
        + kd_ctrl_pkg::SCAN_FLUSH_CYCLES + 4 * kd_ctrl_pkg::NUM_QUERIES + 48);

    logic clk = 1'b0;
    logic rst_n;
    logic load_kdtree;
    logic start;
    logic send_best_cmd;
    logic agg_valid;
    kd_ctrl_pkg::patch_t query_rdata;
    logic kernel_result;
    logic [kd_ctrl_pkg::LEAF_AW-1:0] best_rdata;
    logic out_credit;
    logic agg_credit;
    kd_ctrl_pkg::load_wr_t load_wr;
    kd_ctrl_pkg::mem_rd_t leaf_rd;
    kd_ctrl_pkg::mem_rd_t query_rd;
    kd_ctrl_pkg::kernel_beat_t kernel;
    kd_ctrl_pkg::best_wr_t best_wr;
    kd_ctrl_pkg::mem_rd_t best_rd;
    kd_ctrl_pkg::out_word_t out;
    logic done;

    logic [31:0] rng = 32'hb795;
    logic loading;
    kd_ctrl_pkg::mem_rd_t q_req;
    kd_ctrl_pkg::mem_rd_t b_req;
    int word_idx;
    int beat_idx;
    int qrd_idx;
    int result_idx;
    int flush_cnt;
    int rd_idx;
    int enq_idx;
    int fifo_credits;
    int fifo_level;

    kd_ctrl_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic kd_ctrl_pkg::patch_t patch_of(input int q);
        kd_ctrl_pkg::patch_t p;
        for (int e = 0; e < kd_ctrl_pkg::PATCH_SIZE; e++) begin
            p[e] = kd_ctrl_pkg::DATA_WIDTH'(q * 37 + e * 101 - 300);
        end
        return p;
    endfunction

    // word k of the load stream: nodes, then leaves, then queries
    function automatic bit load_ok(input int k, input kd_ctrl_pkg::load_wr_t w);
        int leaf_k;
        int q;
        leaf_k = k - kd_ctrl_pkg::NUM_NODES;
        q = leaf_k - LEAF_WORDS;
        if (k < kd_ctrl_pkg::NUM_NODES) begin
            return w.node_en && (w.node_addr == kd_ctrl_pkg::NODE_AW'(k))
                && (w.leaf_bank_sel == '0) && !w.query_en;
        end else if (leaf_k < LEAF_WORDS) begin
            return !w.node_en && !w.query_en
                && (w.leaf_bank_sel == (kd_ctrl_pkg::LEAF_SIZE'(1) << (leaf_k % 8)))
                && (w.leaf_addr == kd_ctrl_pkg::LEAF_AW'(leaf_k / 8));
        end
        return !w.node_en && (w.leaf_bank_sel == '0) && w.query_en
            && (q < kd_ctrl_pkg::NUM_QUERIES) && (w.query_addr == kd_ctrl_pkg::QUERY_AW'(q));
    endfunction

    function automatic bit beat_ok(input int b, input kd_ctrl_pkg::kernel_beat_t k,
                                   input kd_ctrl_pkg::mem_rd_t lr);
        int n;
        n = b % kd_ctrl_pkg::NUM_LEAVES;
        return (b < SCAN_BEATS) && (k.first == (n == 0))
            && (k.last == (n == kd_ctrl_pkg::NUM_LEAVES - 1))
            && lr.en && (lr.addr == kd_ctrl_pkg::RD_AW'(n))
            && (k.patch == patch_of(b / kd_ctrl_pkg::NUM_LEAVES));
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("ERR at %0t: %s", $time, msg));
    endtask

    // aggregator, spends one credit per word and injects commands mid-load
    task automatic feed_tree();
        int credits;
        int sent;
        credits = kd_ctrl_pkg::LOAD_CREDITS;
        sent = 0;
        while (sent < LOAD_WORDS || credits < kd_ctrl_pkg::LOAD_CREDITS) begin
            if (agg_credit) begin
                credits++;
            end
            rng = lcg_next(rng);
            if (sent < LOAD_WORDS && credits > 0 && rng[16]) begin
                agg_valid = 1'b1;
                credits--;
                sent++;
            end else begin
                agg_valid = 1'b0;
            end
            start = (sent == 20);
            send_best_cmd = (sent == 40);
            @(negedge clk);
        end
        agg_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        q_req <= query_rd;
        b_req <= best_rd;
    end

    // query and best memories answer one cycle after the read
    initial begin
        query_rdata = '0;
        best_rdata = '0;
        forever begin
            @(negedge clk);
            if (q_req.en) begin
                query_rdata = patch_of(int'(q_req.addr));
            end
            if (b_req.en) begin
                best_rdata = kd_ctrl_pkg::LEAF_AW'(kd_ctrl_pkg::NUM_LEAVES - 1
                                                   - int'(b_req.addr));
            end
        end
    end

    // one kernel result per query, on its last beat
    initial begin
        kernel_result = 1'b0;
        forever begin
            @(negedge clk);
            kernel_result = kernel.valid && kernel.last;
        end
    end

    // output FIFO drains at random, which starves the reader of credits
    initial begin
        out_credit = 1'b0;
        fifo_level = 0;
        forever begin
            @(negedge clk);
            out_credit = 1'b0;
            if (fifo_level > 0) begin
                rng = lcg_next(rng);
                if (rng[17:16] == 2'b00) begin
                    out_credit = 1'b1;
                    fifo_level--;
                end
            end
            if (out.enq) begin
                fifo_level++;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_idx <= 0;
            beat_idx <= 0;
            qrd_idx <= 0;
            result_idx <= 0;
            flush_cnt <= 0;
            rd_idx <= 0;
            enq_idx <= 0;
            fifo_credits <= kd_ctrl_pkg::OUT_CREDITS;
        end else begin
            if (agg_valid) begin
                word_idx <= word_idx + 1;
            end
            if (kernel.valid) begin
                beat_idx <= beat_idx + 1;
            end
            if (query_rd.en) begin
                qrd_idx <= qrd_idx + 1;
            end
            if (done) begin
                result_idx <= 0;
            end else if (kernel_result) begin
                result_idx <= result_idx + 1;
            end
            // flush cycles after the final beat
            if (kernel.valid && kernel.last && beat_idx == SCAN_BEATS - 1) begin
                flush_cnt <= 1;
            end else if (flush_cnt == kd_ctrl_pkg::SCAN_FLUSH_CYCLES) begin
                flush_cnt <= 0;
            end else if (flush_cnt != 0) begin
                flush_cnt <= flush_cnt + 1;
            end
            if (best_rd.en) begin
                rd_idx <= rd_idx + 1;
            end
            if (out.enq) begin
                enq_idx <= enq_idx + 1;
            end
            if (out.enq && !out_credit) begin
                fifo_credits <= fifo_credits - 1;
            end else if (!out.enq && out_credit) begin
                fifo_credits <= fifo_credits + 1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !agg_credit
        && !load_wr.node_en && (load_wr.leaf_bank_sel == '0) && !load_wr.query_en
        && !leaf_rd.en && !query_rd.en && !kernel.valid && !best_wr.en && !best_rd.en
        && !out.enq && !done)
        else report_mismatch("control output active after reset");

    load_order: assert property (@(posedge clk) disable iff (!rst_n)
        agg_valid |-> load_ok(word_idx, load_wr))
        else report_mismatch($sformatf("wrong load write for word %0d", word_idx));

    load_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !agg_valid |-> !load_wr.node_en && (load_wr.leaf_bank_sel == '0) && !load_wr.query_en)
        else report_mismatch("load write without a word");

    // each word hands its credit back exactly one cycle later
    credit_after_word: assert property (@(posedge clk) disable iff (!rst_n)
        agg_credit == $past(agg_valid))
        else report_mismatch("input credit does not follow its word by one cycle");

    commands_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        loading |-> !kernel.valid && !query_rd.en && !best_rd.en)
        else report_mismatch("command acted on during load");

    beat_order: assert property (@(posedge clk) disable iff (!rst_n)
        kernel.valid |-> beat_ok(beat_idx, kernel, leaf_rd))
        else report_mismatch($sformatf("wrong kernel beat %0d", beat_idx));

    query_read: assert property (@(posedge clk) disable iff (!rst_n)
        query_rd.en |-> (qrd_idx < kd_ctrl_pkg::NUM_QUERIES)
            && (query_rd.addr == kd_ctrl_pkg::RD_AW'(qrd_idx)))
        else report_mismatch($sformatf("wrong query read %0d", qrd_idx));

    read_then_beat: assert property (@(posedge clk) disable iff (!rst_n)
        query_rd.en |=> kernel.valid && kernel.first)
        else report_mismatch("first beat does not follow query read");

    best_write: assert property (@(posedge clk) disable iff (!rst_n)
        (best_wr.en == kernel_result)
            && (!best_wr.en || best_wr.addr == kd_ctrl_pkg::QUERY_AW'(result_idx)))
        else report_mismatch($sformatf("wrong best write for result %0d", result_idx));

    done_timing: assert property (@(posedge clk) disable iff (!rst_n)
        done == (flush_cnt == kd_ctrl_pkg::SCAN_FLUSH_CYCLES))
        else report_mismatch($sformatf("done at flush cycle %0d", flush_cnt));

    best_clear: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> best_wr.addr == '0)
        else report_mismatch("best write address not cleared by done");

    readout_value: assert property (@(posedge clk) disable iff (!rst_n)
        out.enq |-> (enq_idx < kd_ctrl_pkg::NUM_QUERIES) && (fifo_credits > 0)
            && (out.leaf_idx == kd_ctrl_pkg::LEAF_AW'(kd_ctrl_pkg::NUM_LEAVES - 1 - enq_idx)))
        else report_mismatch($sformatf("wrong enqueue %0d", enq_idx));

    readout_read: assert property (@(posedge clk) disable iff (!rst_n)
        best_rd.en |-> !out.enq && (fifo_credits > 0) && (rd_idx < kd_ctrl_pkg::NUM_QUERIES)
            && (best_rd.addr == kd_ctrl_pkg::RD_AW'(rd_idx)))
        else report_mismatch($sformatf("wrong best read %0d", rd_idx));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin
        rst_n = 1'b0;
        load_kdtree = 1'b0;
        start = 1'b0;
        send_best_cmd = 1'b0;
        agg_valid = 1'b0;
        loading = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        load_kdtree = 1'b1;
        @(negedge clk);
        load_kdtree = 1'b0;
        loading = 1'b1;
        feed_tree();
        loading = 1'b0;

        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        do @(negedge clk); while (!done);
        assert (beat_idx == SCAN_BEATS && qrd_idx == kd_ctrl_pkg::NUM_QUERIES
                && result_idx == kd_ctrl_pkg::NUM_QUERIES)
            else report_mismatch($sformatf("scan ended after %0d beats", beat_idx));

        repeat (2) @(negedge clk);
        send_best_cmd = 1'b1;
        @(negedge clk);
        send_best_cmd = 1'b0;
        do @(negedge clk); while (enq_idx < kd_ctrl_pkg::NUM_QUERIES);
        do @(negedge clk); while (fifo_credits != kd_ctrl_pkg::OUT_CREDITS);
        repeat (4) @(negedge clk);
        assert (enq_idx == kd_ctrl_pkg::NUM_QUERIES && rd_idx == kd_ctrl_pkg::NUM_QUERIES)
            else report_mismatch($sformatf("readout made %0d enqueues", enq_idx));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* sources.f */
rtl/kd_ctrl_pkg.sv
rtl/phase_fsm.sv
rtl/phase_counter.sv
rtl/load_writer.sv
rtl/scan_sequencer.sv
rtl/result_reader.sv
rtl/kd_ctrl_top.sv
tests/kd_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= kd_ctrl_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# the binary exits non-zero when the testbench hits $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
